//--- udp_tx_top.f
+incdir+rtl
rtl/udp_tx_pkg.sv
rtl/udp_tx_regs.sv
rtl/udp_payload_ram.sv
rtl/eth_crc32.sv
rtl/udp_frame_tx.sv
rtl/udp_tx_top.sv
tests/tb_udp_tx.sv

//--- Bender.yml
package:
  name: udp_tx

export_include_dirs:
  - rtl

sources:
  - rtl/udp_tx_pkg.sv
  - rtl/udp_tx_regs.sv
  - rtl/udp_payload_ram.sv
  - rtl/eth_crc32.sv
  - rtl/udp_frame_tx.sv
  - rtl/udp_tx_top.sv
  - target: test
    files:
      - tests/tb_udp_tx.sv

//--- tests/tb_udp_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_cfg.svh"

module tb_udp_tx import udp_tx_pkg::*; ();

	typedef logic [7:0] byte_q_t [$];

	localparam int NUM_FRAMES = 14;
	localparam int FRAME_CYC = `UDP_TX_MAX_PAYLOAD + 54 + 3 + `UDP_TX_IFG;
	localparam int AXI_CYC = (`UDP_TX_RAM_WORDS + 32) * 8; // payload load and register access
	localparam int MAX_CYCLES = 2 * (NUM_FRAMES * (FRAME_CYC + AXI_CYC) + 20);

	logic clk;
	logic rst_n;
	axil_req_t axil_req;
	axil_resp_t axil_resp;
	logic gmii_tx_en;
	logic [7:0] gmii_txd;

	frame_cfg_t cfg_sh; // what the registers hold
	logic [7:0] pay [`UDP_TX_MAX_PAYLOAD];
	byte_q_t cap_q, got_q, exp_q, exp_bytes;
	int exp_lens [$];
	int exp_pos = 0;
	int reg_errors = 0;
	int frame_errors = 0;
	int cycles = 0;
	int frames_sent = 0;
	int frames_checked = 0;
	logic tx_en_d = 1'b0;
	event frame_ev;

	udp_tx_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_resp(axil_resp),
		.gmii_tx_en(gmii_tx_en),
		.gmii_txd(gmii_txd)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// sample away from the driving edge
	always @(negedge clk) begin
		if (gmii_tx_en) begin
			cap_q.push_back(gmii_txd);
		end else if (tx_en_d) begin
			got_q = cap_q;
			cap_q.delete();
			-> frame_ev;
		end
		tx_en_d = gmii_tx_en;
	end

	function automatic byte_q_t build_frame(input frame_cfg_t c,
			input logic [7:0] p [`UDP_TX_MAX_PAYLOAD], input logic [15:0] ident);
		byte_q_t f;
		byte_q_t q;
		logic [7:0] ip [20];
		logic [15:0] ip_len;
		logic [63:0] udp;
		logic [31:0] sum;
		logic [31:0] crc;
		ip_len = 16'(c.payload_len) + 16'd28;
		ip = '{8'h45, 8'h00, ip_len[15:8], ip_len[7:0], ident[15:8], ident[7:0],
			8'h40, 8'h00, 8'h80, 8'd17, 8'h00, 8'h00,
			c.src_ip[31:24], c.src_ip[23:16], c.src_ip[15:8], c.src_ip[7:0],
			c.dst_ip[31:24], c.dst_ip[23:16], c.dst_ip[15:8], c.dst_ip[7:0]};
		sum = 32'd0;
		for (int i = 0; i < 20; i += 2)
			sum += {16'd0, ip[i], ip[i + 1]};
		sum = sum[15:0] + sum[31:16];
		sum = sum[15:0] + sum[31:16]; // carry out of the first fold
		ip[10] = ~sum[15:8];
		ip[11] = ~sum[7:0];
		udp = {c.src_port, c.dst_port, 16'(c.payload_len) + 16'd8, 16'h0000};
		for (int i = 5; i >= 0; i--)
			f.push_back(c.dst_mac[8 * i +: 8]);
		for (int i = 5; i >= 0; i--)
			f.push_back(c.src_mac[8 * i +: 8]);
		f.push_back(8'h08);
		f.push_back(8'h00);
		foreach (ip[i])
			f.push_back(ip[i]);
		for (int i = 7; i >= 0; i--)
			f.push_back(udp[8 * i +: 8]);
		for (int i = 0; i < int'(c.payload_len); i++)
			f.push_back(p[i]);
		crc = '1;
		foreach (f[i])
			for (int b = 0; b < 8; b++)
				crc = (crc[0] ^ f[i][b]) ? (crc >> 1) ^ 32'hedb8_8320 : crc >> 1;
		crc = ~crc;
		for (int i = 0; i < 4; i++)
			f.push_back(crc[8 * i +: 8]); // fcs low byte first
		repeat (7)
			q.push_back(8'h55);
		q.push_back(8'hd5);
		foreach (f[i])
			q.push_back(f[i]);
		return q;
	endfunction

	function automatic logic [10:0] clamp_len(input int raw);
		if (raw < `UDP_TX_MIN_PAYLOAD)
			return 11'(`UDP_TX_MIN_PAYLOAD);
		if (raw > `UDP_TX_MAX_PAYLOAD)
			return 11'(`UDP_TX_MAX_PAYLOAD);
		return 11'(raw);
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			reg_errors++;
			$display("Fail at %0t: %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic check_frame(input byte_q_t got, input byte_q_t exp);
		int n;
		int bad;
		n = (got.size() < exp.size()) ? got.size() : exp.size();
		bad = -1;
		for (int i = 0; i < n; i++)
			if (bad < 0 && got[i] !== exp[i])
				bad = i;
		if (got.size() != exp.size()) begin
			frame_errors++;
			$display("Fail at %0t: gmii_tx_en length got %0d expected %0d",
				$time, got.size(), exp.size());
		end
		if (bad >= 0) begin
			frame_errors++;
			$display("Fail at %0t: gmii_txd byte %0d got %02h expected %02h",
				$time, bad, got[bad], exp[bad]);
		end
	endtask

	always begin
		@(frame_ev);
		if (frames_checked >= exp_lens.size()) begin
			frame_errors++;
			$display("Unexpected frame of %0d bytes at %0t with no start pending",
				got_q.size(), $time);
		end else begin
			exp_q.delete();
			for (int i = 0; i < exp_lens[frames_checked]; i++)
				exp_q.push_back(exp_bytes[exp_pos + i]);
			exp_pos += exp_lens[frames_checked];
			check_frame(got_q, exp_q);
		end
		frames_checked++;
	end

	task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
		axil_req.aw_valid = 1'b1;
		axil_req.aw_addr = addr;
		axil_req.w_valid = 1'b1;
		axil_req.w_data = data;
		axil_req.w_strb = 4'hf;
		do begin
			@(posedge clk);
			#1;
		end while (!axil_resp.aw_ready);
		check_word("w_ready", 32'(axil_resp.w_ready), 32'd1); // w accepted with aw
		@(posedge clk); // aw and w accepted here
		#1;
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid = 1'b0;
		axil_req.b_ready = 1'b1;
		while (!axil_resp.b_valid) begin
			@(posedge clk);
			#1;
		end
		check_word("b_resp", 32'(axil_resp.b_resp), 32'd0);
		@(posedge clk);
		#1;
		axil_req.b_ready = 1'b0;
	endtask

	task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
		axil_req.ar_valid = 1'b1;
		axil_req.ar_addr = addr;
		do begin
			@(posedge clk);
			#1;
		end while (!axil_resp.ar_ready);
		@(posedge clk);
		#1;
		axil_req.ar_valid = 1'b0;
		axil_req.r_ready = 1'b1;
		while (!axil_resp.r_valid) begin
			@(posedge clk);
			#1;
		end
		data = axil_resp.r_data;
		check_word("r_resp", 32'(axil_resp.r_resp), 32'd0);
		@(posedge clk);
		#1;
		axil_req.r_ready = 1'b0;
	endtask

	task automatic expect_reg(input logic [11:0] addr, input string name,
			input logic [31:0] exp);
		logic [31:0] got;
		axil_read(addr, got);
		check_word(name, got, exp);
	endtask

	task automatic expect_status(input logic busy);
		logic [15:0] cnt;
		cnt = busy ? 16'(frames_sent - 1) : 16'(frames_sent); // current frame not yet counted
		expect_reg(`UDP_TX_REG_STATUS, "status", {cnt, 15'd0, busy});
	endtask

	task automatic program_cfg();
		axil_write(`UDP_TX_REG_DST_MAC_LO, cfg_sh.dst_mac[31:0]);
		axil_write(`UDP_TX_REG_DST_MAC_HI, {16'd0, cfg_sh.dst_mac[47:32]});
		axil_write(`UDP_TX_REG_SRC_MAC_LO, cfg_sh.src_mac[31:0]);
		axil_write(`UDP_TX_REG_SRC_MAC_HI, {16'd0, cfg_sh.src_mac[47:32]});
		axil_write(`UDP_TX_REG_SRC_IP, cfg_sh.src_ip);
		axil_write(`UDP_TX_REG_DST_IP, cfg_sh.dst_ip);
		axil_write(`UDP_TX_REG_PORTS, {cfg_sh.src_port, cfg_sh.dst_port});
		axil_write(`UDP_TX_REG_PAYLOAD_LEN, 32'(cfg_sh.payload_len));
	endtask

	task automatic random_cfg(input int len);
		cfg_sh.dst_mac = {16'($urandom), $urandom};
		cfg_sh.src_mac = {16'($urandom), $urandom};
		cfg_sh.src_ip = $urandom;
		cfg_sh.dst_ip = $urandom;
		cfg_sh.src_port = 16'($urandom);
		cfg_sh.dst_port = 16'($urandom);
		cfg_sh.payload_len = 11'(len);
	endtask

	task automatic set_len(input int raw);
		axil_write(`UDP_TX_REG_PAYLOAD_LEN, 32'(raw));
		cfg_sh.payload_len = clamp_len(raw);
		expect_reg(`UDP_TX_REG_PAYLOAD_LEN, "payload_len", 32'(cfg_sh.payload_len));
	endtask

	// first payload byte is the msb of word 0
	task automatic load_payload(input int n);
		for (int i = 0; i < n; i++)
			pay[i] = 8'($urandom);
		for (int k = 0; k < (n + 3) / 4; k++)
			axil_write(`UDP_TX_RAM_BASE + 12'(4 * k),
				{pay[4 * k], pay[4 * k + 1], pay[4 * k + 2], pay[4 * k + 3]});
	endtask

	task automatic send_frame();
		byte_q_t f;
		f = build_frame(cfg_sh, pay, 16'(frames_sent));
		foreach (f[i])
			exp_bytes.push_back(f[i]);
		exp_lens.push_back(f.size());
		axil_write(`UDP_TX_REG_CTRL, 32'd1);
		frames_sent++;
	endtask

	task automatic wait_frame();
		wait (frames_checked == frames_sent);
		repeat (`UDP_TX_IFG + 2)
			@(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		axil_req = '0;
		foreach (pay[i])
			pay[i] = 8'h00;
		void'($urandom(32'h0be3_3a9a));
		repeat (10)
			@(posedge clk);
		#1;
		rst_n = 1'b1;
		expect_status(1'b0);

		// fixed frame with a 64 byte payload and busy seen mid frame
		cfg_sh = '{dst_mac: 48'h02_00_00_00_00_01, src_mac: 48'h02_00_00_00_00_02,
			src_ip: 32'hc0a8_0001, dst_ip: 32'hc0a8_0002, src_port: 16'd5000,
			dst_port: 16'd6000, payload_len: 11'd64};
		program_cfg();
		load_payload(64);
		send_frame();
		expect_status(1'b1);
		wait_frame();
		expect_status(1'b0);

		for (int r = 0; r < 8; r++) begin
			random_cfg(`UDP_TX_MIN_PAYLOAD + int'($urandom % 1007));
			program_cfg();
			load_payload(cfg_sh.payload_len);
			send_frame();
			wait_frame();
			expect_reg(`UDP_TX_REG_DST_IP, "dst_ip", cfg_sh.dst_ip);
			expect_reg(`UDP_TX_REG_PORTS, "ports", {cfg_sh.src_port, cfg_sh.dst_port});
			expect_status(1'b0);
		end

		set_len(5);
		load_payload(cfg_sh.payload_len);
		send_frame();
		wait_frame();
		set_len(2000);
		load_payload(cfg_sh.payload_len);
		send_frame();
		wait_frame();
		expect_status(1'b0);

		// second start lands while busy
		send_frame();
		axil_write(`UDP_TX_REG_CTRL, 32'd1);
		expect_status(1'b1);
		wait_frame();
		expect_status(1'b0);

		// dst ip changed mid frame only shows in the next one
		send_frame();
		axil_write(`UDP_TX_REG_DST_IP, 32'h0a00_0063);
		wait_frame();
		cfg_sh.dst_ip = 32'h0a00_0063;
		expect_reg(`UDP_TX_REG_DST_IP, "dst_ip", cfg_sh.dst_ip);
		send_frame();
		wait_frame();
		expect_status(1'b0);

		$display("register errors: %0d, frame errors: %0d, frames sent: %0d, checked: %0d",
			reg_errors, frame_errors, frames_sent, frames_checked);
		if (reg_errors == 0 && frame_errors == 0 && frames_checked == frames_sent)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/udp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_tx_top import udp_tx_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire axil_req_t axil_req,
	output axil_resp_t axil_resp,
	output logic gmii_tx_en,
	output logic [7:0] gmii_txd
);

	frame_cfg_t cfg;
	logic start, busy, frame_done;
	logic ram_we;
	logic [`UDP_TX_RAM_AW-1:0] ram_waddr, ram_raddr;
	logic [31:0] ram_wdata, ram_rdata;
	logic crc_clr, crc_en;
	logic [7:0] crc_byte;
	logic [31:0] crc;

	udp_tx_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_resp(axil_resp),
		.cfg(cfg),
		.start(start),
		.busy(busy),
		.frame_done(frame_done),
		.ram_we(ram_we),
		.ram_waddr(ram_waddr),
		.ram_wdata(ram_wdata)
	);

	udp_payload_ram u_ram (
		.clk(clk),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.raddr(ram_raddr),
		.rdata(ram_rdata)
	);

	udp_frame_tx u_frame_tx (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.start(start),
		.busy(busy),
		.frame_done(frame_done),
		.ram_raddr(ram_raddr),
		.ram_rdata(ram_rdata),
		.crc_clr(crc_clr),
		.crc_en(crc_en),
		.crc_byte(crc_byte),
		.crc(crc),
		.tx_en(gmii_tx_en), // registered in the sequencer
		.tx_data(gmii_txd)
	);

	eth_crc32 u_crc (
		.clk(clk),
		.rst_n(rst_n),
		.clr(crc_clr),
		.en(crc_en),
		.data(crc_byte),
		.crc(crc)
	);

endmodule

`default_nettype wire

//--- rtl/udp_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_frame_tx import udp_tx_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire frame_cfg_t cfg,
	input wire logic start,
	output logic busy,
	output logic frame_done,
	output logic [`UDP_TX_RAM_AW-1:0] ram_raddr,
	input wire logic [31:0] ram_rdata,
	output logic crc_clr,
	output logic crc_en,
	output logic [7:0] crc_byte,
	input wire logic [31:0] crc,
	output logic tx_en,
	output logic [7:0] tx_data
);

	tx_state_e state, state_nxt;
	logic [10:0] cnt, cnt_last;
	frame_cfg_t cfg_q;
	logic [15:0] ident;
	logic [15:0] ip_len, udp_len, csum;
	logic [19:0] sum;
	logic [335:0] hdr; // eth, ipv4 and udp headers, shifted out msb first
	logic [3:0][7:0] pay_word;
	logic [3:0][7:0] fcs;
	logic [7:0] nxt_byte;
	logic nxt_en;

	assign ip_len = 16'(cfg_q.payload_len) + 16'd28;
	assign udp_len = 16'(cfg_q.payload_len) + 16'd8;
	assign csum = ~(sum[15:0] + {15'd0, sum[16]}); // final carry fold
	assign fcs = ~crc;
	assign busy = state != st_idle;
	assign frame_done = state == st_gap && cnt == cnt_last;

	always_comb begin
		state_nxt = st_idle;
		cnt_last = '0;
		case (state)
			st_checksum: begin
				cnt_last = 11'd2;
				state_nxt = st_preamble;
			end
			st_preamble: begin
				cnt_last = 11'd7;
				state_nxt = st_eth_hdr;
			end
			st_eth_hdr: begin
				cnt_last = 11'd13;
				state_nxt = st_ip_hdr;
			end
			st_ip_hdr: begin
				cnt_last = 11'd19;
				state_nxt = st_udp_hdr;
			end
			st_udp_hdr: begin
				cnt_last = 11'd7;
				state_nxt = st_payload;
			end
			st_payload: begin
				cnt_last = cfg_q.payload_len - 11'd1;
				state_nxt = st_fcs;
			end
			st_fcs: begin
				cnt_last = 11'd3;
				state_nxt = st_gap;
			end
			st_gap: cnt_last = 11'(`UDP_TX_IFG - 1);
			default: ;
		endcase
	end

	// next byte on the wire, also fed to the crc in the same cycle
	always_comb begin
		nxt_byte = 8'h00;
		nxt_en = 1'b0;
		crc_clr = 1'b0;
		crc_en = 1'b0;
		case (state)
			st_preamble: begin
				nxt_byte = (cnt == 11'd7) ? 8'hd5 : 8'h55; // sfd last
				nxt_en = 1'b1;
				crc_clr = 1'b1;
			end
			st_eth_hdr, st_ip_hdr, st_udp_hdr: begin
				nxt_byte = hdr[335:328];
				nxt_en = 1'b1;
				crc_en = 1'b1;
			end
			st_payload: begin
				nxt_byte = pay_word[~cnt[1:0]];
				nxt_en = 1'b1;
				crc_en = 1'b1;
			end
			st_fcs: begin
				nxt_byte = fcs[cnt[1:0]]; // low byte first
				nxt_en = 1'b1;
			end
			default: ;
		endcase
	end

	assign crc_byte = nxt_byte;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cnt <= '0;
			ident <= '0;
			ram_raddr <= '0;
			tx_en <= 1'b0;
			tx_data <= 8'h00;
		end else begin
			tx_en <= nxt_en;
			tx_data <= nxt_byte;
			if (state == st_idle) begin
				cnt <= '0;
				ram_raddr <= '0;
				if (start)
					state <= st_checksum;
			end else if (cnt == cnt_last) begin
				cnt <= '0;
				state <= state_nxt;
				if (state == st_udp_hdr)
					ram_raddr <= 8'd1; // word 0 already fetched
				if (state == st_gap)
					ident <= ident + 16'd1;
			end else begin
				cnt <= cnt + 11'd1;
			end
			if (state == st_payload && cnt[1:0] == 2'd3)
				ram_raddr <= ram_raddr + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start)
			cfg_q <= cfg; // later register writes wait for the next frame
		if (state == st_checksum) begin
			case (cnt)
				11'd0: sum <= 20'h4500 + ip_len + ident + 20'h4000 + 20'h8011
					+ cfg_q.src_ip[31:16] + cfg_q.src_ip[15:0]
					+ cfg_q.dst_ip[31:16] + cfg_q.dst_ip[15:0];
				11'd1: sum <= {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
				default: hdr <= {cfg_q.dst_mac, cfg_q.src_mac, 16'h0800,
					8'h45, 8'h00, ip_len, ident, 16'h4000, 8'h80, 8'd17, csum,
					cfg_q.src_ip, cfg_q.dst_ip,
					cfg_q.src_port, cfg_q.dst_port, udp_len, 16'h0000};
			endcase
		end
		if (state == st_eth_hdr || state == st_ip_hdr || state == st_udp_hdr)
			hdr <= {hdr[327:0], 8'h00};
		if ((state == st_udp_hdr && cnt == 11'd7) || (state == st_payload && cnt[1:0] == 2'd3))
			pay_word <= ram_rdata;
	end

endmodule

`default_nettype wire

//--- rtl/eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic clr,
	input wire logic en,
	input wire logic [7:0] data,
	output logic [31:0] crc
);

	logic [31:0] crc_nxt;

	// 0x04c11db7 in reflected form, lsb of each byte first
	always_comb begin
		crc_nxt = crc;
		for (int i = 0; i < 8; i++) begin
			if (crc_nxt[0] ^ data[i])
				crc_nxt = (crc_nxt >> 1) ^ 32'hedb8_8320;
			else
				crc_nxt = crc_nxt >> 1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crc <= '1;
		else if (clr)
			crc <= '1; // preset for the next frame
		else if (en)
			crc <= crc_nxt;
	end

endmodule

`default_nettype wire

//--- rtl/udp_payload_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_payload_ram (
	input wire logic clk,
	input wire logic we,
	input wire logic [`UDP_TX_RAM_AW-1:0] waddr,
	input wire logic [31:0] wdata,
	input wire logic [`UDP_TX_RAM_AW-1:0] raddr,
	output logic [31:0] rdata
);

	logic [31:0] mem [`UDP_TX_RAM_WORDS]; // msb is the first byte on the wire

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // one cycle read latency
	end

endmodule

`default_nettype wire

//--- rtl/udp_tx_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_tx_regs import udp_tx_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire axil_req_t axil_req,
	output axil_resp_t axil_resp,
	output frame_cfg_t cfg,
	output logic start,
	input wire logic busy,
	input wire logic frame_done,
	output logic ram_we,
	output logic [`UDP_TX_RAM_AW-1:0] ram_waddr,
	output logic [31:0] ram_wdata
);

	logic aw_rdy, ar_rdy, b_vld, r_vld;
	logic [31:0] r_dat;
	logic wr_go, rd_go, wr_hs, rd_hs;
	logic [11:0] wr_off, rd_off;
	logic in_ram;
	logic [31:0] wmask, wr_cur, wr_val, rd_val;
	logic [15:0] frame_cnt;

	// current value of a register as seen by the bus
	function automatic logic [31:0] reg_value(input logic [11:0] off);
		case (off)
			`UDP_TX_REG_STATUS: return {frame_cnt, 15'd0, busy};
			`UDP_TX_REG_DST_MAC_LO: return cfg.dst_mac[31:0];
			`UDP_TX_REG_DST_MAC_HI: return {16'd0, cfg.dst_mac[47:32]};
			`UDP_TX_REG_SRC_MAC_LO: return cfg.src_mac[31:0];
			`UDP_TX_REG_SRC_MAC_HI: return {16'd0, cfg.src_mac[47:32]};
			`UDP_TX_REG_SRC_IP: return cfg.src_ip;
			`UDP_TX_REG_DST_IP: return cfg.dst_ip;
			`UDP_TX_REG_PORTS: return {cfg.src_port, cfg.dst_port};
			`UDP_TX_REG_PAYLOAD_LEN: return {21'd0, cfg.payload_len};
			default: return 32'd0; // ctrl and ram window read zero
		endcase
	endfunction

	assign wr_off = {axil_req.aw_addr[11:2], 2'b00};
	assign rd_off = {axil_req.ar_addr[11:2], 2'b00};
	assign in_ram = (axil_req.aw_addr & ~12'h3ff) == `UDP_TX_RAM_BASE;
	assign wmask = {{8{axil_req.w_strb[3]}}, {8{axil_req.w_strb[2]}},
		{8{axil_req.w_strb[1]}}, {8{axil_req.w_strb[0]}}};

	// one transaction in flight, pending responses hold off new ones
	assign wr_go = axil_req.aw_valid & axil_req.w_valid & ~aw_rdy & ~b_vld & ~ar_rdy & ~r_vld;
	assign rd_go = axil_req.ar_valid & ~ar_rdy & ~r_vld & ~aw_rdy & ~b_vld & ~wr_go;
	assign wr_hs = aw_rdy & axil_req.aw_valid & axil_req.w_valid;
	assign rd_hs = ar_rdy & axil_req.ar_valid;

	always_comb begin
		wr_cur = reg_value(wr_off);
		rd_val = reg_value(rd_off);
		wr_val = (wr_cur & ~wmask) | (axil_req.w_data & wmask); // byte strobes
	end

	assign axil_resp = '{aw_ready: aw_rdy, w_ready: aw_rdy, b_valid: b_vld, b_resp: 2'b00,
		ar_ready: ar_rdy, r_valid: r_vld, r_data: r_dat, r_resp: 2'b00};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_rdy <= 1'b0;
			ar_rdy <= 1'b0;
			b_vld <= 1'b0;
			r_vld <= 1'b0;
			start <= 1'b0;
			ram_we <= 1'b0;
			frame_cnt <= '0;
			cfg <= '{payload_len: 11'(`UDP_TX_MIN_PAYLOAD), default: '0};
		end else begin
			aw_rdy <= wr_go; // single-cycle ready
			ar_rdy <= rd_go;
			start <= 1'b0;
			ram_we <= 1'b0;
			if (wr_hs)
				b_vld <= 1'b1;
			else if (axil_req.b_ready)
				b_vld <= 1'b0;
			if (rd_hs)
				r_vld <= 1'b1;
			else if (axil_req.r_ready)
				r_vld <= 1'b0;
			if (frame_done)
				frame_cnt <= frame_cnt + 16'd1;
			if (wr_hs) begin
				ram_we <= in_ram;
				case (wr_off)
					`UDP_TX_REG_CTRL: start <= wr_val[0] & ~busy; // dropped while busy
					`UDP_TX_REG_DST_MAC_LO: cfg.dst_mac[31:0] <= wr_val;
					`UDP_TX_REG_DST_MAC_HI: cfg.dst_mac[47:32] <= wr_val[15:0];
					`UDP_TX_REG_SRC_MAC_LO: cfg.src_mac[31:0] <= wr_val;
					`UDP_TX_REG_SRC_MAC_HI: cfg.src_mac[47:32] <= wr_val[15:0];
					`UDP_TX_REG_SRC_IP: cfg.src_ip <= wr_val;
					`UDP_TX_REG_DST_IP: cfg.dst_ip <= wr_val;
					`UDP_TX_REG_PORTS: {cfg.src_port, cfg.dst_port} <= wr_val;
					`UDP_TX_REG_PAYLOAD_LEN: begin
						if (wr_val < `UDP_TX_MIN_PAYLOAD)
							cfg.payload_len <= 11'(`UDP_TX_MIN_PAYLOAD);
						else if (wr_val > `UDP_TX_MAX_PAYLOAD)
							cfg.payload_len <= 11'(`UDP_TX_MAX_PAYLOAD);
						else
							cfg.payload_len <= wr_val[10:0];
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs)
			r_dat <= rd_val;
		if (wr_hs) begin
			ram_waddr <= axil_req.aw_addr[`UDP_TX_RAM_AW+1:2]; // word address
			ram_wdata <= axil_req.w_data;
		end
	end

endmodule

`default_nettype wire

//--- rtl/udp_tx_pkg.sv
`default_nettype none

`include "udp_tx_cfg.svh"

package udp_tx_pkg;

	typedef struct packed {
		logic aw_valid;
		logic [`UDP_TX_ADDR_W-1:0] aw_addr;
		logic w_valid;
		logic [`UDP_TX_DATA_W-1:0] w_data;
		logic [`UDP_TX_DATA_W/8-1:0] w_strb;
		logic b_ready;
		logic ar_valid;
		logic [`UDP_TX_ADDR_W-1:0] ar_addr;
		logic r_ready;
	} axil_req_t;

	typedef struct packed {
		logic aw_ready;
		logic w_ready;
		logic b_valid;
		logic [1:0] b_resp;
		logic ar_ready;
		logic r_valid;
		logic [`UDP_TX_DATA_W-1:0] r_data;
		logic [1:0] r_resp;
	} axil_resp_t;

	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] src_port;
		logic [15:0] dst_port;
		logic [10:0] payload_len; // bytes, 18 to 1024
	} frame_cfg_t;

	typedef enum logic [3:0] {
		st_idle,
		st_checksum, // ipv4 header sum, 3 cycles
		st_preamble,
		st_eth_hdr,
		st_ip_hdr,
		st_udp_hdr,
		st_payload,
		st_fcs,
		st_gap
	} tx_state_e;

endpackage

`default_nettype wire

//--- rtl/udp_tx_cfg.svh
`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

// AXI4-Lite bus widths
`define UDP_TX_ADDR_W 12
`define UDP_TX_DATA_W 32

`define UDP_TX_RAM_WORDS 256 // 1024 payload bytes
`define UDP_TX_RAM_AW 8
`define UDP_TX_MIN_PAYLOAD 18 // no ethernet padding below this
`define UDP_TX_MAX_PAYLOAD 1024
`define UDP_TX_IFG 12 // idle cycles after the fcs

`define UDP_TX_REG_CTRL 12'h000
`define UDP_TX_REG_STATUS 12'h004
`define UDP_TX_REG_DST_MAC_LO 12'h008
`define UDP_TX_REG_DST_MAC_HI 12'h00c
`define UDP_TX_REG_SRC_MAC_LO 12'h010
`define UDP_TX_REG_SRC_MAC_HI 12'h014
`define UDP_TX_REG_SRC_IP 12'h018
`define UDP_TX_REG_DST_IP 12'h01c
`define UDP_TX_REG_PORTS 12'h020
`define UDP_TX_REG_PAYLOAD_LEN 12'h024
`define UDP_TX_RAM_BASE 12'h400 // write-only payload window

`endif
